// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

    ////////////////////
    // address and data
    ////////////////////

    localparam int ADDR_WIDTH     = 16;
    localparam int DATA_WIDTH     = 32;
    localparam int BYTE_SEL_WIDTH = DATA_WIDTH / 8;

    ////////////////////
    // cache geometry
    ////////////////////

    // word select inside one block
    localparam int OFFSET_WIDTH = 3;
    localparam int BLOCK_WORDS  = 1 << OFFSET_WIDTH;

    // set select
    localparam int INDEX_WIDTH = 2;
    localparam int SETS        = 1 << INDEX_WIDTH;

    // two ways, one lru bit per set
    localparam int WAYS = 2;

    // tag is what is left above index, offset and the two byte bits
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;

    ////////////////////
    // enums
    ////////////////////

    // processor rw and memory mem_rw share this encoding
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FILL,
        ST_RESPOND
    } cache_state_e;

endpackage

// ==== logic/dcache_req_if.sv ====
interface dcache_req_if;
    import dcache_pkg::*;

    // accepted request, held until the next acceptance
    logic                      req_valid;
    mem_op_e                   req_rw;
    logic [TAG_WIDTH-1:0]      req_tag;
    logic [INDEX_WIDTH-1:0]    req_index;
    logic [OFFSET_WIDTH-1:0]   req_offset;
    logic [DATA_WIDTH-1:0]     req_wdata;
    logic [BYTE_SEL_WIDTH-1:0] req_byte_sel;

    // controller can take a new request
    logic                      core_idle;

    modport latch (
        output req_valid, req_rw, req_tag, req_index, req_offset, req_wdata, req_byte_sel,
        input  core_idle
    );

    modport core (
        input  req_valid, req_rw, req_tag, req_index, req_offset, req_wdata, req_byte_sel,
        output core_idle
    );

endinterface

// ==== logic/dcache_mem_if.sv ====
interface dcache_mem_if;
    import dcache_pkg::*;

    // burst request from the controller
    logic                    burst_start;
    mem_op_e                 burst_op;
    logic [ADDR_WIDTH-1:0]   burst_addr;
    logic [DATA_WIDTH-1:0]   wb_data;

    // per-word traffic and completion from the engine
    logic                    fill_valid;
    logic [OFFSET_WIDTH-1:0] fill_word;
    logic [DATA_WIDTH-1:0]   fill_data;
    logic [OFFSET_WIDTH-1:0] wb_word;
    logic                    burst_done;

    modport core (
        output burst_start, burst_op, burst_addr, wb_data,
        input  fill_valid, fill_word, fill_data, wb_word, burst_done
    );

    modport engine (
        input  burst_start, burst_op, burst_addr, wb_data,
        output fill_valid, fill_word, fill_data, wb_word, burst_done
    );

endinterface

// ==== logic/dcache_request_latch.sv ====
module dcache_request_latch (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  enable,
    input  dcache_pkg::mem_op_e                   rw,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]     addr,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]     write,
    input  logic [dcache_pkg::BYTE_SEL_WIDTH-1:0] mem_sel,
    output logic                                  ready,
    dcache_req_if.latch                           req
);
    import dcache_pkg::*;

    // bit positions of the address fields, byte bits sit below the offset
    localparam int TAG_LSB    = ADDR_WIDTH - TAG_WIDTH;
    localparam int INDEX_LSB  = TAG_LSB - INDEX_WIDTH;
    localparam int OFFSET_LSB = INDEX_LSB - OFFSET_WIDTH;

    logic accept;

    // only one request in flight
    assign accept = enable && req.core_idle;
    assign ready  = req.core_idle;

    ////////////////////
    // strobe
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req.req_valid <= 1'b0;
        end
        else
        begin
            req.req_valid <= accept;
        end
    end

    ////////////////////
    // request fields
    ////////////////////

    // the processor may change its inputs after this edge
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req.req_rw       <= rw;
            req.req_tag      <= addr[TAG_LSB +: TAG_WIDTH];
            req.req_index    <= addr[INDEX_LSB +: INDEX_WIDTH];
            req.req_offset   <= addr[OFFSET_LSB +: OFFSET_WIDTH];
            req.req_wdata    <= write;
            req.req_byte_sel <= mem_sel;
        end
    end

endmodule

// ==== logic/dcache_controller.sv ====
module dcache_controller (
    input  logic                              clk,
    input  logic                              rst_n,
    dcache_req_if.core                        req,
    dcache_mem_if.core                        mem,
    output logic [dcache_pkg::DATA_WIDTH-1:0] read,
    output logic                              rw_valid
);
    import dcache_pkg::*;

    cache_state_e state;

    // storage
    logic [TAG_WIDTH-1:0]  tag_arr   [SETS][WAYS];
    logic [DATA_WIDTH-1:0] data_arr  [SETS][WAYS][BLOCK_WORDS];
    logic [WAYS-1:0]       valid_arr [SETS];
    logic [WAYS-1:0]       dirty_arr [SETS];
    // set bit names the least recently used way
    logic [SETS-1:0]       lru;

    logic [WAYS-1:0]       way_hit;
    logic                  hit;
    logic                  hit_way;
    logic                  victim_sel;
    logic                  victim_way;
    logic                  word_way;
    logic                  fill_we;
    logic                  word_we;
    logic                  is_write;
    logic [DATA_WIDTH-1:0] old_word;
    logic [DATA_WIDTH-1:0] merged_word;

    function automatic logic [ADDR_WIDTH-1:0] block_addr(
        input logic [TAG_WIDTH-1:0]   tag,
        input logic [INDEX_WIDTH-1:0] index
    );
        return {tag, index, {(ADDR_WIDTH - TAG_WIDTH - INDEX_WIDTH){1'b0}}};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] merge_bytes(
        input logic [DATA_WIDTH-1:0]     old_w,
        input logic [DATA_WIDTH-1:0]     new_w,
        input logic [BYTE_SEL_WIDTH-1:0] sel
    );
        logic [DATA_WIDTH-1:0] res;
        res = old_w;
        for (int b = 0; b < BYTE_SEL_WIDTH; b++)
        begin
            if (sel[b])
            begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////
    // lookup
    ////////////////////

    always_comb
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            way_hit[w] = valid_arr[req.req_index][w]
                         && (tag_arr[req.req_index][w] == req.req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // empty way first, lru way otherwise
    always_comb
    begin
        if (!valid_arr[req.req_index][0])
            victim_sel = 1'b0;
        else if (!valid_arr[req.req_index][1])
            victim_sel = 1'b1;
        else
            victim_sel = lru[req.req_index];
    end

    assign is_write    = (req.req_rw == MEM_WRITE);
    assign word_way    = (state == ST_LOOKUP) ? hit_way : victim_way;
    assign old_word    = data_arr[req.req_index][word_way][req.req_offset];
    assign merged_word = merge_bytes(old_word, req.req_wdata, req.req_byte_sel);

    assign fill_we = (state == ST_FILL) && mem.fill_valid;
    // write hit, or pending write once the fill is complete
    assign word_we = is_write && (((state == ST_LOOKUP) && hit)
                                  || ((state == ST_FILL) && mem.burst_done));

    assign mem.wb_data  = data_arr[req.req_index][victim_way][mem.wb_word];
    assign req.core_idle = (state == ST_IDLE) && !req.req_valid;
    assign rw_valid      = (state == ST_RESPOND);

    ////////////////////
    // arrays
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (fill_we)
            data_arr[req.req_index][victim_way][mem.fill_word] <= mem.fill_data;
        else if (word_we)
            data_arr[req.req_index][word_way][req.req_offset] <= merged_word;

        if ((state == ST_FILL) && mem.burst_done)
            tag_arr[req.req_index][victim_way] <= req.req_tag;
    end

    ////////////////////
    // miss FSM
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state          <= ST_IDLE;
            valid_arr      <= '{default: '0};
            dirty_arr      <= '{default: '0};
            lru            <= '0;
            victim_way     <= 1'b0;
            read           <= '0;
            mem.burst_start <= 1'b0;
            mem.burst_op   <= MEM_READ;
            mem.burst_addr <= '0;
        end
        else
        begin
            mem.burst_start <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (req.req_valid)
                        state <= ST_LOOKUP;
                end
                ST_LOOKUP:
                begin
                    if (hit)
                    begin
                        lru[req.req_index] <= ~hit_way;
                        if (is_write)
                        begin
                            dirty_arr[req.req_index][hit_way] <= 1'b1;
                            read <= '0;
                        end
                        else
                        begin
                            read <= old_word;
                        end
                        state <= ST_RESPOND;
                    end
                    else
                    begin
                        victim_way      <= victim_sel;
                        mem.burst_start <= 1'b1;
                        if (valid_arr[req.req_index][victim_sel]
                            && dirty_arr[req.req_index][victim_sel])
                        begin
                            // old block goes back to its own address first
                            mem.burst_op   <= MEM_WRITE;
                            mem.burst_addr <= block_addr(tag_arr[req.req_index][victim_sel],
                                                         req.req_index);
                            state          <= ST_WRITEBACK;
                        end
                        else
                        begin
                            mem.burst_op   <= MEM_READ;
                            mem.burst_addr <= block_addr(req.req_tag, req.req_index);
                            state          <= ST_FILL;
                        end
                    end
                end
                ST_WRITEBACK:
                begin
                    if (mem.burst_done)
                    begin
                        dirty_arr[req.req_index][victim_way] <= 1'b0;
                        mem.burst_start <= 1'b1;
                        mem.burst_op    <= MEM_READ;
                        mem.burst_addr  <= block_addr(req.req_tag, req.req_index);
                        state           <= ST_FILL;
                    end
                end
                ST_FILL:
                begin
                    // read miss answers with the word straight from memory
                    if (mem.fill_valid && !is_write && (mem.fill_word == req.req_offset))
                        read <= mem.fill_data;
                    if (mem.burst_done)
                    begin
                        valid_arr[req.req_index][victim_way] <= 1'b1;
                        dirty_arr[req.req_index][victim_way] <= is_write;
                        lru[req.req_index] <= ~victim_way;
                        if (is_write)
                            read <= '0;
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND:
                begin
                    state <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/dcache_burst_engine.sv ====
module dcache_burst_engine (
    input  logic                              clk,
    input  logic                              rst_n,
    dcache_mem_if.engine                      mem,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic                              mem_enable,
    output dcache_pkg::mem_op_e               mem_rw,
    output logic [dcache_pkg::DATA_WIDTH-1:0] mem_write,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] mem_read,
    input  logic                              mem_read_valid,
    input  logic                              mem_write_req,
    input  logic                              mem_last
);
    import dcache_pkg::*;

    logic [OFFSET_WIDTH-1:0] word_cnt;
    logic                    xfer;

    // one word moves in this cycle, gaps just leave this low
    assign xfer = mem_enable && ((mem_rw == MEM_READ) ? mem_read_valid : mem_write_req);

    ////////////////////
    // word traffic
    ////////////////////

    // fill words go to the controller as they arrive
    assign mem.fill_valid = mem_enable && (mem_rw == MEM_READ) && mem_read_valid;
    assign mem.fill_word  = word_cnt;
    assign mem.fill_data  = mem_read;

    // next unsent write-back word, picked from the array by the counter
    assign mem.wb_word = word_cnt;
    assign mem_write   = mem.wb_data;

    ////////////////////
    // burst control
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_enable     <= 1'b0;
            mem_rw         <= MEM_READ;
            mem_addr       <= '0;
            word_cnt       <= '0;
            mem.burst_done <= 1'b0;
        end
        else
        begin
            mem.burst_done <= 1'b0;
            if (mem.burst_start)
            begin
                // address and direction stay put for the whole burst
                mem_enable <= 1'b1;
                mem_rw     <= mem.burst_op;
                mem_addr   <= mem.burst_addr;
                word_cnt   <= '0;
            end
            else if (xfer)
            begin
                word_cnt <= word_cnt + 1'b1;
                if (mem_last)
                begin
                    mem_enable     <= 1'b0;
                    mem.burst_done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/dcache_top.sv ====
module dcache_top (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // processor side
    input  logic                                  enable,
    input  dcache_pkg::mem_op_e                   rw,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]     addr,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]     write,
    input  logic [dcache_pkg::BYTE_SEL_WIDTH-1:0] mem_sel,
    output logic [dcache_pkg::DATA_WIDTH-1:0]     read,
    output logic                                  rw_valid,
    output logic                                  ready,

    // memory controller side
    output logic [dcache_pkg::ADDR_WIDTH-1:0]     mem_addr,
    output logic                                  mem_enable,
    output dcache_pkg::mem_op_e                   mem_rw,
    output logic [dcache_pkg::DATA_WIDTH-1:0]     mem_write,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]     mem_read,
    input  logic                                  mem_read_valid,
    input  logic                                  mem_write_req,
    input  logic                                  mem_last
);

    dcache_req_if req_bus ();
    dcache_mem_if mem_bus ();

    dcache_request_latch i_request_latch (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (enable),
        .rw      (rw),
        .addr    (addr),
        .write   (write),
        .mem_sel (mem_sel),
        .ready   (ready),
        .req     (req_bus.latch)
    );

    dcache_controller i_controller (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_bus.core),
        .mem      (mem_bus.core),
        .read     (read),
        .rw_valid (rw_valid)
    );

    dcache_burst_engine i_burst_engine (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem            (mem_bus.engine),
        .mem_addr       (mem_addr),
        .mem_enable     (mem_enable),
        .mem_rw         (mem_rw),
        .mem_write      (mem_write),
        .mem_read       (mem_read),
        .mem_read_valid (mem_read_valid),
        .mem_write_req  (mem_write_req),
        .mem_last       (mem_last)
    );

endmodule

// ==== sim/tb_dcache_mem_model.sv ====
module tb_dcache_mem_model (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr,
    input  logic                              mem_enable,
    input  dcache_pkg::mem_op_e               mem_rw,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] mem_write,
    output logic [dcache_pkg::DATA_WIDTH-1:0] mem_read,
    output logic                              mem_read_valid,
    output logic                              mem_write_req,
    output logic                              mem_last,
    output int                                fill_count,
    output int                                wb_count
);
    import dcache_pkg::*;

    localparam int WORD_BITS = ADDR_WIDTH - 2;
    localparam int MAX_GAP   = 3;

    logic [DATA_WIDTH-1:0]   mem_arr [1 << WORD_BITS];
    logic                    active;
    mem_op_e                 op;
    logic [WORD_BITS-1:0]    base;
    logic [OFFSET_WIDTH-1:0] word_idx;
    int                      gap;
    int                      next_gap;
    logic                    strobe;

    // word address in both halves, inverted in the low one
    function automatic logic [DATA_WIDTH-1:0] init_word(input logic [WORD_BITS-1:0] waddr);
        return {2'b10, waddr, 2'b01, ~waddr};
    endfunction

    task automatic send_word(input logic [OFFSET_WIDTH-1:0] idx);
        if (op == MEM_READ)
        begin
            mem_read       <= mem_arr[base | idx];
            mem_read_valid <= 1'b1;
        end
        else
        begin
            mem_write_req <= 1'b1;
        end
        mem_last <= (idx == BLOCK_WORDS - 1);
    endtask

    assign strobe = mem_read_valid || mem_write_req;

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < (1 << WORD_BITS); i++)
                mem_arr[i] <= init_word(i);
            active         <= 1'b0;
            op             <= MEM_READ;
            base           <= '0;
            word_idx       <= '0;
            gap            <= 0;
            mem_read       <= '0;
            mem_read_valid <= 1'b0;
            mem_write_req  <= 1'b0;
            mem_last       <= 1'b0;
            fill_count     <= 0;
            wb_count       <= 0;
        end
        else
        begin
            mem_read_valid <= 1'b0;
            mem_write_req  <= 1'b0;
            mem_last       <= 1'b0;
            if (strobe)
            begin
                // the engine takes this word on the same edge
                if (mem_write_req)
                    mem_arr[base | word_idx] <= mem_write;
                if (mem_last)
                begin
                    active <= 1'b0;
                end
                else
                begin
                    next_gap = $urandom_range(0, MAX_GAP);
                    word_idx <= word_idx + 1'b1;
                    gap      <= next_gap;
                    if (next_gap == 0)
                        send_word(word_idx + 1'b1);
                end
            end
            else if (!active && mem_enable)
            begin
                active   <= 1'b1;
                op       <= mem_rw;
                base     <= mem_addr[ADDR_WIDTH-1:2];
                word_idx <= '0;
                gap      <= $urandom_range(0, MAX_GAP);
                if (mem_rw == MEM_WRITE)
                    wb_count <= wb_count + 1;
                else
                    fill_count <= fill_count + 1;
            end
            else if (active)
            begin
                if (gap > 1)
                    gap <= gap - 1;
                else
                    send_word(word_idx);
            end
        end
    end

endmodule

// ==== sim/tb_dcache.sv ====
module tb_dcache;
    import dcache_pkg::*;

    localparam int CLK_PERIOD        = 100;
    localparam int RESET_CYCLES      = 16;
    localparam int SEED              = 95009;
    localparam int RANDOM_REQUESTS   = 400;
    localparam int DIRECTED_REQUESTS = 9 + 16 + 6 + 4;
    localparam int TIMEOUT_CYCLES    = (RANDOM_REQUESTS + DIRECTED_REQUESTS) * 60 + 200;
    // acceptance edge to the edge that samples rw_valid
    localparam int HIT_LATENCY       = 3;
    localparam int SEL_BITS          = DATA_WIDTH / 8;
    localparam int INDEX_BITS        = 2;
    localparam int SET_COUNT         = 1 << INDEX_BITS;
    localparam int WORD_BITS         = ADDR_WIDTH - 2;
    localparam int TAG_LSB           = OFFSET_WIDTH + INDEX_BITS;
    localparam int TAG_BITS          = WORD_BITS - TAG_LSB;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  enable;
    mem_op_e               rw;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] write;
    logic [SEL_BITS-1:0]   mem_sel;
    logic [DATA_WIDTH-1:0] read;
    logic                  rw_valid;
    logic                  ready;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  mem_enable;
    mem_op_e               mem_rw;
    logic [DATA_WIDTH-1:0] mem_write;
    logic [DATA_WIDTH-1:0] mem_read;
    logic                  mem_read_valid;
    logic                  mem_write_req;
    logic                  mem_last;
    int                    fill_count;
    int                    wb_count;

    // shadow memory and shadow tag state
    logic [DATA_WIDTH-1:0] shadow_mem   [1 << WORD_BITS];
    logic [TAG_BITS-1:0]   shadow_tag   [SET_COUNT][2];
    bit                    shadow_valid [SET_COUNT][2];
    bit                    shadow_dirty [SET_COUNT][2];
    bit                    shadow_lru   [SET_COUNT];
    int                    exp_fills = 0;
    int                    exp_wbs = 0;

    // one entry per accepted request
    logic [DATA_WIDTH-1:0] exp_read_q [$];
    bit                    exp_hit_q [$];
    int                    exp_fill_q [$];
    int                    exp_wb_q [$];
    int                    accept_q [$];

    int                    cycle_count = 0;
    int                    resp_latency;

    dcache_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .enable(enable), .rw(rw), .addr(addr), .write(write), .mem_sel(mem_sel),
        .read(read), .rw_valid(rw_valid), .ready(ready),
        .mem_addr(mem_addr), .mem_enable(mem_enable), .mem_rw(mem_rw), .mem_write(mem_write),
        .mem_read(mem_read), .mem_read_valid(mem_read_valid),
        .mem_write_req(mem_write_req), .mem_last(mem_last)
    );

    tb_dcache_mem_model i_mem (
        .clk(clk), .rst_n(rst_n),
        .mem_addr(mem_addr), .mem_enable(mem_enable), .mem_rw(mem_rw), .mem_write(mem_write),
        .mem_read(mem_read), .mem_read_valid(mem_read_valid),
        .mem_write_req(mem_write_req), .mem_last(mem_last),
        .fill_count(fill_count), .wb_count(wb_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // reference
    ////////////////////

    function automatic logic [DATA_WIDTH-1:0] init_word(input logic [WORD_BITS-1:0] waddr);
        return {2'b10, waddr, 2'b01, ~waddr};
    endfunction

    // expected read, plus shadow tag, dirty, lru and burst counts
    function automatic logic [DATA_WIDTH-1:0] reference_access(
        input  mem_op_e               op,
        input  logic [ADDR_WIDTH-1:0] a,
        input  logic [DATA_WIDTH-1:0] d,
        input  logic [SEL_BITS-1:0]   sel,
        output bit                    is_hit
    );
        logic [WORD_BITS-1:0]  waddr;
        logic [TAG_BITS-1:0]   tag;
        logic [DATA_WIDTH-1:0] word;
        int                    set_idx;
        int                    way;
        waddr   = a[ADDR_WIDTH-1:2];
        set_idx = waddr[OFFSET_WIDTH +: INDEX_BITS];
        tag     = waddr[WORD_BITS-1:TAG_LSB];
        is_hit  = 1'b0;
        way     = 0;
        for (int w = 0; w < 2; w++)
        begin
            if (shadow_valid[set_idx][w] && (shadow_tag[set_idx][w] == tag))
            begin
                is_hit = 1'b1;
                way    = w;
            end
        end
        if (!is_hit)
        begin
            if (!shadow_valid[set_idx][0])
                way = 0;
            else if (!shadow_valid[set_idx][1])
                way = 1;
            else
                way = shadow_lru[set_idx];
            if (shadow_valid[set_idx][way] && shadow_dirty[set_idx][way])
                exp_wbs++;
            exp_fills++;
            shadow_tag[set_idx][way]   = tag;
            shadow_valid[set_idx][way] = 1'b1;
            shadow_dirty[set_idx][way] = 1'b0;
        end
        // lru names the way not used last
        shadow_lru[set_idx] = (way == 0);
        if (op == MEM_WRITE)
        begin
            shadow_dirty[set_idx][way] = 1'b1;
            word = shadow_mem[waddr];
            for (int b = 0; b < SEL_BITS; b++)
            begin
                if (sel[b])
                    word[8*b +: 8] = d[8*b +: 8];
            end
            shadow_mem[waddr] = word;
            return '0;
        end
        return shadow_mem[waddr];
    endfunction

    task automatic check_value(
        input string                 name,
        input logic [DATA_WIDTH-1:0] actual,
        input logic [DATA_WIDTH-1:0] expected
    );
        if (actual !== expected)
        begin
            $display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////

    task automatic issue(
        input mem_op_e               op,
        input logic [ADDR_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] d,
        input logic [SEL_BITS-1:0]   sel
    );
        logic [DATA_WIDTH-1:0] exp_word;
        bit                    exp_hit;
        @(posedge clk);
        while (!ready)
            @(posedge clk);
        enable  <= 1'b1;
        rw      <= op;
        addr    <= a;
        write   <= d;
        mem_sel <= sel;
        @(posedge clk);
        // accepted on this edge
        enable   <= 1'b0;
        exp_word = reference_access(op, a, d, sel, exp_hit);
        exp_read_q.push_back(exp_word);
        exp_hit_q.push_back(exp_hit);
        exp_fill_q.push_back(exp_fills);
        exp_wb_q.push_back(exp_wbs);
        accept_q.push_back(cycle_count);
    endtask

    task automatic wait_drain();
        @(posedge clk);
        while ((exp_read_q.size() != 0) || !ready)
            @(posedge clk);
    endtask

    ////////////////////
    // comparison
    ////////////////////

    always @(posedge clk)
    begin
        if (rst_n && rw_valid)
        begin
            if (exp_read_q.size() == 0)
            begin
                $display("ERROR: rw_valid came without an accepted request");
                $display("Simulation failed");
                $fatal(1, "unexpected response");
            end
            else
            begin
                check_value("read", read, exp_read_q.pop_front());
                check_value("ready", ready, 1'b0);
                check_value("fill_count", fill_count, exp_fill_q.pop_front());
                check_value("wb_count", wb_count, exp_wb_q.pop_front());
                resp_latency = cycle_count - accept_q.pop_front();
                if (exp_hit_q.pop_front())
                    check_value("rw_valid latency", resp_latency, HIT_LATENCY);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("ERROR: timeout after %0d cycles with requests still open", cycle_count);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // tests
    ////////////////////

    initial
    begin
        int                    count_before;
        int                    pred_before;
        logic [ADDR_WIDTH-1:0] a;
        void'($urandom(SEED));
        rst_n   = 1'b0;
        enable  = 1'b0;
        rw      = MEM_READ;
        addr    = '0;
        write   = '0;
        mem_sel = '0;
        for (int i = 0; i < (1 << WORD_BITS); i++)
            shadow_mem[i] = init_word(i);
        for (int s = 0; s < SET_COUNT; s++)
        begin
            shadow_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++)
            begin
                shadow_tag[s][w]   = '0;
                shadow_valid[s][w] = 1'b0;
                shadow_dirty[s][w] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // idle state after reset
        check_value("ready", ready, 1'b1);
        check_value("rw_valid", rw_valid, 1'b0);
        check_value("mem_enable", mem_enable, 1'b0);
        check_value("mem_rw", mem_rw, MEM_READ);
        check_value("read", read, '0);

        // one block in set 0, miss then hits
        count_before = fill_count;
        issue(MEM_READ, 16'h0100, '0, '0);
        for (int w = 0; w < BLOCK_WORDS; w++)
            issue(MEM_READ, 16'h0100 + 4 * w, '0, '0);
        wait_drain();
        check_value("fill_count delta", fill_count - count_before, 1);

        // byte-masked writes in set 2
        for (int i = 0; i < 8; i++)
        begin
            a = 16'h0540 + 4 * $urandom_range(0, BLOCK_WORDS - 1);
            issue(MEM_WRITE, a, $urandom, $urandom_range(0, (1 << SEL_BITS) - 1));
            issue(MEM_READ, a, '0, '0);
        end

        // set 1 touched as A, B, A, C
        issue(MEM_READ, 16'h0820, '0, '0);
        issue(MEM_READ, 16'h1020, '0, '0);
        issue(MEM_READ, 16'h0820, '0, '0);
        issue(MEM_READ, 16'h1820, '0, '0);
        wait_drain();
        count_before = fill_count;
        issue(MEM_READ, 16'h0820, '0, '0);
        wait_drain();
        check_value("fill_count delta", fill_count - count_before, 0);
        issue(MEM_READ, 16'h1020, '0, '0);
        wait_drain();
        check_value("fill_count delta", fill_count - count_before, 1);

        // dirty block in set 3 evicted and reread
        count_before = wb_count;
        pred_before  = exp_wbs;
        issue(MEM_WRITE, 16'h02E8, 32'hA5C3_0F96, 4'hF);
        issue(MEM_READ, 16'h0360, '0, '0);
        issue(MEM_READ, 16'h03E0, '0, '0);
        issue(MEM_READ, 16'h02E8, '0, '0);
        wait_drain();
        check_value("wb_count delta", wb_count - count_before, exp_wbs - pred_before);

        // random traffic over tags 0 to 7 in every set
        for (int i = 0; i < RANDOM_REQUESTS; i++)
        begin
            a = $urandom_range(0, 16'h03FF);
            if ($urandom_range(0, 1) == 1)
                issue(MEM_WRITE, a, $urandom, $urandom_range(0, (1 << SEL_BITS) - 1));
            else
                issue(MEM_READ, a, '0, '0);
        end
        wait_drain();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/dcache_pkg.sv
logic/dcache_req_if.sv
logic/dcache_mem_if.sv
logic/dcache_request_latch.sv
logic/dcache_controller.sv
logic/dcache_burst_engine.sv
logic/dcache_top.sv
sim/tb_dcache_mem_model.sv
sim/tb_dcache.sv
